/* source/bus_pkg.sv */
package bus_pkg;

  localparam int AddrW = 4;
  localparam int DataW = 8;

  // one bus request held stable by the master until ack
  typedef struct packed {
    logic             we;
    logic [AddrW-1:0] adr;
    logic [DataW-1:0] dat;
    logic             stb;
  } wb_req_t;

  typedef struct packed {
    logic [DataW-1:0] dat;
    logic             ack;
  } wb_rsp_t;

  // peripheral slots on the bus
  localparam logic [AddrW-1:0] SlotRgb     = AddrW'(0);
  localparam logic [AddrW-1:0] SlotDebug   = AddrW'(1);
  localparam logic [AddrW-1:0] SlotCharlie = AddrW'(2);

endpackage

/* source/uart_pkg.sv */
package uart_pkg;

  // write flag on top of the op byte and address in the low nibble
  localparam int OpWriteBit = 7;

  // start, eight data bits, stop
  localparam int FrameBits = 10;

  // 7 pins with each pair lit in both directions
  localparam int NumCharlieLeds = 42;

endpackage

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx
  import uart_pkg::*;
#(
  parameter int ClksPerBit = 16
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       uart_rx_ni,
  output logic [7:0] rx_data_o,
  output logic       rx_valid_o
);

  localparam int CntW    = $clog2(ClksPerBit);
  localparam int BitW    = $clog2(FrameBits);
  localparam int HalfBit = ClksPerBit / 2;

  logic [2:0]      sync_q;
  logic            busy_q;
  logic            valid_q;
  logic [CntW-1:0] cnt_q;
  logic [BitW-1:0] bit_q;
  logic [7:0]      shift_q;
  logic            line;
  logic            fall;

  // two flops against metastability and a third for the edge
  assign line = sync_q[1];
  assign fall = sync_q[2] && !sync_q[1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q  <= '1;
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
      bit_q   <= '0;
    end else begin
      sync_q  <= {sync_q[1:0], uart_rx_ni};
      valid_q <= 1'b0;
      if (!busy_q) begin
        if (fall) begin
          busy_q <= 1'b1;
          cnt_q  <= CntW'(HalfBit - 1);
          bit_q  <= '0;
        end
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        // mid-bit sample point
        cnt_q <= CntW'(ClksPerBit - 1);
        bit_q <= bit_q + 1'b1;
        if (bit_q == '0) begin
          // start bit high again means a glitch
          busy_q <= !line;
        end else if (bit_q == BitW'(FrameBits - 1)) begin
          busy_q  <= 1'b0;
          valid_q <= line;
        end
      end
    end
  end

  // lsb first
  always_ff @(posedge clk_i) begin
    if (busy_q && cnt_q == '0 && bit_q != '0 && bit_q != BitW'(FrameBits - 1)) begin
      shift_q <= {line, shift_q[7:1]};
    end
  end

  assign rx_data_o  = shift_q;
  assign rx_valid_o = valid_q;

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
  import uart_pkg::*;
#(
  parameter int ClksPerBit = 16
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic [7:0] tx_data_i,
  input  logic       tx_start_i,
  output logic       tx_busy_o,
  output logic       uart_tx_no
);

  localparam int CntW = $clog2(ClksPerBit);
  localparam int BitW = $clog2(FrameBits);

  logic [FrameBits-1:0] shift_q;
  logic [CntW-1:0]      cnt_q;
  logic [BitW-1:0]      bit_q;
  logic                 busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // line idles high
      shift_q <= '1;
      cnt_q   <= '0;
      bit_q   <= '0;
      busy_q  <= 1'b0;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        shift_q <= {1'b1, tx_data_i, 1'b0};
        cnt_q   <= CntW'(ClksPerBit - 1);
        bit_q   <= '0;
        busy_q  <= 1'b1;
      end
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end else if (bit_q == BitW'(FrameBits - 1)) begin
      busy_q <= 1'b0;
    end else begin
      shift_q <= {1'b1, shift_q[FrameBits-1:1]};
      cnt_q   <= CntW'(ClksPerBit - 1);
      bit_q   <= bit_q + 1'b1;
    end
  end

  assign tx_busy_o  = busy_q;
  assign uart_tx_no = shift_q[0];

endmodule

/* source/ctrl_uart.sv */
`timescale 1ns/1ps

module ctrl_uart
  import bus_pkg::*;
  import uart_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [DataW-1:0] rx_data_i,
  input  logic             rx_valid_i,
  output logic [DataW-1:0] tx_data_o,
  output logic             tx_start_o,
  input  logic             tx_busy_i,
  output wb_req_t          wb_req_o,
  input  wb_rsp_t          wb_rsp_i
);

  typedef enum logic [2:0] {
    StIdle,
    StWaitData,
    StBusWrite,
    StBusRead,
    StReply
  } state_e;

  state_e           state_q;
  logic             stb_q;
  logic             tx_start_q;
  logic [AddrW-1:0] adr_q;
  logic [DataW-1:0] data_q;
  logic [DataW-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= StIdle;
      stb_q      <= 1'b0;
      tx_start_q <= 1'b0;
    end else begin
      tx_start_q <= 1'b0;
      case (state_q)
        StIdle: begin
          if (rx_valid_i) begin
            state_q <= rx_data_i[OpWriteBit] ? StWaitData : StBusRead;
          end
        end
        StWaitData: begin
          if (rx_valid_i) begin
            state_q <= StBusWrite;
          end
        end
        StBusWrite, StBusRead: begin
          // strobe up, then drop it right after ack
          if (!stb_q) begin
            stb_q <= 1'b1;
          end else if (wb_rsp_i.ack) begin
            stb_q   <= 1'b0;
            state_q <= (state_q == StBusWrite) ? StBusRead : StReply;
          end
        end
        StReply: begin
          if (!tx_busy_i) begin
            tx_start_q <= 1'b1;
            state_q    <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && rx_valid_i) begin
      adr_q <= rx_data_i[AddrW-1:0];
    end
    if (state_q == StWaitData && rx_valid_i) begin
      data_q <= rx_data_i;
    end
    // readback after a write lands here too
    if (state_q == StBusRead && stb_q && wb_rsp_i.ack) begin
      rdata_q <= wb_rsp_i.dat;
    end
  end

  assign wb_req_o = '{we: state_q == StBusWrite, adr: adr_q, dat: data_q, stb: stb_q};

  assign tx_data_o  = rdata_q;
  assign tx_start_o = tx_start_q;

  tx_start_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_start_o |-> !tx_busy_i);

endmodule

/* source/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder
  import bus_pkg::*;
(
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  output wb_req_t rgb_req_o,
  input  wb_rsp_t rgb_rsp_i,
  output wb_req_t dbg_req_o,
  input  wb_rsp_t dbg_rsp_i,
  output wb_req_t chx_req_o,
  input  wb_rsp_t chx_rsp_i
);

  always_comb begin
    // we, adr and dat go to everyone
    rgb_req_o     = wb_req_i;
    dbg_req_o     = wb_req_i;
    chx_req_o     = wb_req_i;
    rgb_req_o.stb = wb_req_i.stb && (wb_req_i.adr == SlotRgb);
    dbg_req_o.stb = wb_req_i.stb && (wb_req_i.adr == SlotDebug);
    chx_req_o.stb = wb_req_i.stb && (wb_req_i.adr == SlotCharlie);

    case (wb_req_i.adr)
      SlotRgb:     wb_rsp_o = rgb_rsp_i;
      SlotDebug:   wb_rsp_o = dbg_rsp_i;
      SlotCharlie: wb_rsp_o = chx_rsp_i;
      // unmapped slots ack in the same cycle and read zero
      default:     wb_rsp_o = '{dat: '0, ack: wb_req_i.stb};
    endcase
  end

  always_comb begin
    if (wb_req_i.stb) begin
      assert ($onehot0({rgb_req_o.stb, dbg_req_o.stb, chx_req_o.stb}))
        else $error("more than one peripheral strobed");
    end
  end

endmodule

/* source/peri_rgb_led.sv */
`timescale 1ns/1ps

module peri_rgb_led
  import bus_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  output logic    led_r_o,
  output logic    led_g_o,
  output logic    led_b_o
);

  logic             ack_q;
  logic             we_q;
  logic [DataW-1:0] wdat_q;
  logic [DataW-1:0] level_q;
  logic [1:0]       phase_q;

  always_ff @(posedge clk_i) begin
    if (wb_req_i.stb) begin
      we_q   <= wb_req_i.we;
      wdat_q <= wb_req_i.dat;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q   <= 1'b0;
      level_q <= '0;
      phase_q <= '0;
    end else begin
      ack_q   <= wb_req_i.stb && !ack_q;
      phase_q <= phase_q + 1'b1;
      if (ack_q && we_q) begin
        level_q <= wdat_q;
      end
    end
  end

  assign wb_rsp_o = '{dat: level_q, ack: ack_q};

  // on for level cycles out of every four
  assign led_r_o = phase_q < level_q[1:0];
  assign led_g_o = phase_q < level_q[3:2];
  assign led_b_o = phase_q < level_q[5:4];

  ack_after_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_rsp_o.ack |-> $past(wb_req_i.stb) && wb_req_i.stb);

endmodule

/* source/peri_debug.sv */
`timescale 1ns/1ps

module peri_debug
  import bus_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  wb_req_t          wb_req_i,
  output wb_rsp_t          wb_rsp_o,
  output logic [DataW-1:0] debug_o
);

  logic             ack_q;
  logic             we_q;
  logic [DataW-1:0] wdat_q;
  logic [DataW-1:0] dbg_q;

  always_ff @(posedge clk_i) begin
    if (wb_req_i.stb) begin
      we_q   <= wb_req_i.we;
      wdat_q <= wb_req_i.dat;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      dbg_q <= '0;
    end else begin
      ack_q <= wb_req_i.stb && !ack_q;
      if (ack_q && we_q) begin
        dbg_q <= wdat_q;
      end
    end
  end

  assign wb_rsp_o = '{dat: dbg_q, ack: ack_q};
  assign debug_o  = dbg_q;

  ack_after_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_rsp_o.ack |-> $past(wb_req_i.stb) && wb_req_i.stb);

endmodule

/* source/peri_charlieplex.sv */
`timescale 1ns/1ps

module peri_charlieplex
  import bus_pkg::*;
  import uart_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  wb_req_t    wb_req_i,
  output wb_rsp_t    wb_rsp_o,
  output logic [6:0] charlieplex_o,
  output logic [6:0] charlieplex_out_en_o
);

  localparam int NumPins = 7;

  logic             ack_q;
  logic             we_q;
  logic [DataW-1:0] wdat_q;
  logic [DataW-1:0] idx_q;
  logic             valid_q;
  logic [2:0]       anode;
  logic [2:0]       offset;
  logic [2:0]       cathode;

  always_ff @(posedge clk_i) begin
    if (wb_req_i.stb) begin
      we_q   <= wb_req_i.we;
      wdat_q <= wb_req_i.dat;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q   <= 1'b0;
      idx_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      ack_q <= wb_req_i.stb && !ack_q;
      if (ack_q && we_q) begin
        idx_q   <= wdat_q;
        valid_q <= 1'b1;
      end
    end
  end

  assign wb_rsp_o = '{dat: idx_q, ack: ack_q};

  // each anode owns six leds, cathode skips the anode pin
  assign anode   = 3'(idx_q / DataW'(NumPins - 1));
  assign offset  = 3'(idx_q % DataW'(NumPins - 1));
  assign cathode = (offset < anode) ? offset : offset + 3'd1;

  always_comb begin
    charlieplex_o        = '0;
    charlieplex_out_en_o = '0;
    if (valid_q && idx_q < DataW'(NumCharlieLeds)) begin
      charlieplex_o[anode]          = 1'b1;
      charlieplex_out_en_o[anode]   = 1'b1;
      charlieplex_out_en_o[cathode] = 1'b1;
    end
  end

endmodule

/* source/top.sv */
`timescale 1ns/1ps

module top
  import bus_pkg::*;
#(
  parameter int ClksPerBit = 16
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       uart_rx_ni,
  output logic       uart_tx_no,
  output logic       led_r_o,
  output logic       led_g_o,
  output logic       led_b_o,
  output logic [7:0] led_debug_o,
  output logic [6:0] charlieplex_o,
  output logic [6:0] charlieplex_out_en_o
);

  logic [7:0] rx_data;
  logic       rx_valid;
  logic [7:0] tx_data;
  logic       tx_start;
  logic       tx_busy;
  wb_req_t    ctrl_req;
  wb_rsp_t    ctrl_rsp;
  wb_req_t    rgb_req;
  wb_rsp_t    rgb_rsp;
  wb_req_t    dbg_req;
  wb_rsp_t    dbg_rsp;
  wb_req_t    chx_req;
  wb_rsp_t    chx_rsp;

  uart_rx #(.ClksPerBit(ClksPerBit)) u_uart_rx (
    .clk_i,
    .rst_n_i,
    .uart_rx_ni,
    .rx_data_o  (rx_data),
    .rx_valid_o (rx_valid)
  );

  uart_tx #(.ClksPerBit(ClksPerBit)) u_uart_tx (
    .clk_i,
    .rst_n_i,
    .tx_data_i  (tx_data),
    .tx_start_i (tx_start),
    .tx_busy_o  (tx_busy),
    .uart_tx_no
  );

  ctrl_uart u_ctrl (
    .clk_i,
    .rst_n_i,
    .rx_data_i  (rx_data),
    .rx_valid_i (rx_valid),
    .tx_data_o  (tx_data),
    .tx_start_o (tx_start),
    .tx_busy_i  (tx_busy),
    .wb_req_o   (ctrl_req),
    .wb_rsp_i   (ctrl_rsp)
  );

  bus_decoder u_decoder (
    .wb_req_i  (ctrl_req),
    .wb_rsp_o  (ctrl_rsp),
    .rgb_req_o (rgb_req),
    .rgb_rsp_i (rgb_rsp),
    .dbg_req_o (dbg_req),
    .dbg_rsp_i (dbg_rsp),
    .chx_req_o (chx_req),
    .chx_rsp_i (chx_rsp)
  );

  peri_rgb_led u_rgb (
    .clk_i,
    .rst_n_i,
    .wb_req_i (rgb_req),
    .wb_rsp_o (rgb_rsp),
    .led_r_o,
    .led_g_o,
    .led_b_o
  );

  peri_debug u_debug (
    .clk_i,
    .rst_n_i,
    .wb_req_i (dbg_req),
    .wb_rsp_o (dbg_rsp),
    .debug_o  (led_debug_o)
  );

  peri_charlieplex u_charlie (
    .clk_i,
    .rst_n_i,
    .wb_req_i (chx_req),
    .wb_rsp_o (chx_rsp),
    .charlieplex_o,
    .charlieplex_out_en_o
  );

endmodule

/* verif/tb_top.sv */
`timescale 1ns/1ps

module tb_top
  import bus_pkg::*;
  import uart_pkg::*;
();

  localparam int ClksPerBit = 4;
  localparam int ClkPeriod  = 20;
  // about 25 commands of up to three 40-cycle frames with margin
  localparam int MaxCycles  = 6000;

  logic       clk;
  logic       rst_n;
  logic       uart_rx_n;
  logic       uart_tx_n;
  logic       led_r;
  logic       led_g;
  logic       led_b;
  logic [7:0] led_debug;
  logic [6:0] chx;
  logic [6:0] chx_en;

  int         seed;
  int         err_count;
  int         tests_run;
  int         cycles;
  logic [7:0] last_rgb;
  logic [7:0] last_dbg;
  logic [7:0] last_chx;

  top #(.ClksPerBit(ClksPerBit)) uut (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .uart_rx_ni           (uart_rx_n),
    .uart_tx_no           (uart_tx_n),
    .led_r_o              (led_r),
    .led_g_o              (led_g),
    .led_b_o              (led_b),
    .led_debug_o          (led_debug),
    .charlieplex_o        (chx),
    .charlieplex_out_en_o (chx_en)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MaxCycles);
    $display("TEST FAILED");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
    err_count++;
    $display("MISMATCH at %0t ns: %s expected 0x%02h, got 0x%02h", $time, name, expected,
             actual);
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    tests_run++;
    if (err_count == errs_at_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_count - errs_at_start);
    end
  endtask

  // host uart model with lsb first 8N1 frames
  task automatic send_byte(input logic [7:0] value);
    logic [FrameBits-1:0] frame;
    frame = {1'b1, value, 1'b0};
    @(posedge clk);
    for (int i = 0; i < FrameBits; i++) begin
      uart_rx_n <= frame[i];
      repeat (ClksPerBit) @(posedge clk);
    end
  endtask

  task automatic recv_byte(output logic [7:0] value);
    value = '0;
    @(posedge clk);
    while (uart_tx_n !== 1'b0) begin
      @(posedge clk);
    end
    // move to the middle of the start bit
    repeat (ClksPerBit / 2) @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (ClksPerBit) @(posedge clk);
      value[i] = uart_tx_n;
    end
    repeat (ClksPerBit) @(posedge clk);
    if (uart_tx_n !== 1'b1) begin
      err_count++;
      $display("reply frame at %0t ns has a low stop bit", $time);
    end
  endtask

  task automatic run_command(input logic we, input logic [3:0] adr, input logic [7:0] data,
                             output logic [7:0] reply);
    logic [7:0] op;
    op = '0;
    op[OpWriteBit] = we;
    op[AddrW-1:0] = adr;
    send_byte(op);
    if (we) begin
      send_byte(data);
    end
    recv_byte(reply);
  endtask

  task automatic check_reset_state();
    int start;
    start = err_count;
    if (uart_tx_n !== 1'b1) report_mismatch("uart_tx_no", 8'h01, {7'b0, uart_tx_n});
    if ({led_r, led_g, led_b} !== 3'b000) report_mismatch("led_rgb", 8'h00,
                                                          {5'b0, led_r, led_g, led_b});
    if (led_debug !== 8'h00) report_mismatch("led_debug_o", 8'h00, led_debug);
    if (chx_en !== 7'h00) report_mismatch("charlieplex_out_en_o", 8'h00, {1'b0, chx_en});
    finish_test("reset state", start);
  endtask

  task automatic write_debug_bytes();
    int         start;
    logic [7:0] data;
    logic [7:0] reply;
    start = err_count;
    repeat (4) begin
      data = 8'($random(seed));
      run_command(1'b1, SlotDebug, data, reply);
      if (reply !== data) report_mismatch("debug reply", data, reply);
      if (led_debug !== data) report_mismatch("led_debug_o", data, led_debug);
      last_dbg = data;
    end
    finish_test("debug write", start);
  endtask

  task automatic write_rgb_levels();
    int         start;
    logic [7:0] data;
    logic [7:0] reply;
    logic [2:0] samples [8];
    logic [7:0] cnt_r;
    logic [7:0] cnt_g;
    logic [7:0] cnt_b;
    start = err_count;
    repeat (3) begin
      data = 8'($random(seed));
      run_command(1'b1, SlotRgb, data, reply);
      if (reply !== data) report_mismatch("rgb reply", data, reply);
      for (int i = 0; i < 8; i++) begin
        @(posedge clk);
        samples[i] = {led_r, led_g, led_b};
      end
      // every window of four cycles
      for (int w = 0; w <= 4; w++) begin
        cnt_r = '0;
        cnt_g = '0;
        cnt_b = '0;
        for (int i = w; i < w + 4; i++) begin
          cnt_r = cnt_r + 8'(samples[i][2]);
          cnt_g = cnt_g + 8'(samples[i][1]);
          cnt_b = cnt_b + 8'(samples[i][0]);
        end
        if (cnt_r !== {6'b0, data[1:0]}) report_mismatch("led_r_o on cycles", {6'b0, data[1:0]},
                                                         cnt_r);
        if (cnt_g !== {6'b0, data[3:2]}) report_mismatch("led_g_o on cycles", {6'b0, data[3:2]},
                                                         cnt_g);
        if (cnt_b !== {6'b0, data[5:4]}) report_mismatch("led_b_o on cycles", {6'b0, data[5:4]},
                                                         cnt_b);
      end
      last_rgb = data;
    end
    finish_test("rgb write", start);
  endtask

  task automatic write_charlie_indices();
    int         start;
    int         k;
    int         pos;
    logic [7:0] idx_list [$];
    logic [7:0] reply;
    logic [6:0] exp_en;
    logic [6:0] exp_hi;
    start = err_count;
    idx_list = {8'd0, 8'd5, 8'd6, 8'd35, 8'd41};
    idx_list.push_back(8'($unsigned($random(seed)) % NumCharlieLeds));
    idx_list.push_back(8'd42);
    idx_list.push_back(8'(NumCharlieLeds + $unsigned($random(seed)) % 200));
    foreach (idx_list[n]) begin
      k = int'(idx_list[n]);
      run_command(1'b1, SlotCharlie, idx_list[n], reply);
      if (reply !== idx_list[n]) report_mismatch("charlieplex reply", idx_list[n], reply);
      // count anode and cathode pairs in index order up to k
      exp_en = '0;
      exp_hi = '0;
      pos    = 0;
      for (int a = 0; a < 7; a++) begin
        for (int c = 0; c < 7; c++) begin
          if (c != a) begin
            if (pos == k) begin
              exp_en[a] = 1'b1;
              exp_en[c] = 1'b1;
              exp_hi[a] = 1'b1;
            end
            pos++;
          end
        end
      end
      if (chx_en !== exp_en) report_mismatch("charlieplex_out_en_o", {1'b0, exp_en},
                                             {1'b0, chx_en});
      if ((chx & chx_en) !== exp_hi) report_mismatch("charlieplex_o", {1'b0, exp_hi},
                                                     {1'b0, chx & chx_en});
      last_chx = idx_list[n];
    end
    finish_test("charlieplex write", start);
  endtask

  task automatic probe_unmapped();
    int         start;
    logic [7:0] dbg_before;
    logic [6:0] en_before;
    logic [6:0] hi_before;
    logic [7:0] reply;
    start = err_count;
    dbg_before = led_debug;
    en_before  = chx_en;
    hi_before  = chx;
    run_command(1'b0, 4'd3, 8'h00, reply);
    if (reply !== 8'h00) report_mismatch("read 0x3 reply", 8'h00, reply);
    run_command(1'b0, 4'd15, 8'h00, reply);
    if (reply !== 8'h00) report_mismatch("read 0xf reply", 8'h00, reply);
    run_command(1'b1, 4'd7, 8'($random(seed)), reply);
    if (reply !== 8'h00) report_mismatch("write 0x7 reply", 8'h00, reply);
    run_command(1'b1, 4'd12, 8'($random(seed)), reply);
    if (reply !== 8'h00) report_mismatch("write 0xc reply", 8'h00, reply);
    if (led_debug !== dbg_before) report_mismatch("led_debug_o", dbg_before, led_debug);
    if (chx_en !== en_before) report_mismatch("charlieplex_out_en_o", {1'b0, en_before},
                                              {1'b0, chx_en});
    if (chx !== hi_before) report_mismatch("charlieplex_o", {1'b0, hi_before}, {1'b0, chx});
    finish_test("unmapped", start);
  endtask

  task automatic read_back_slots();
    int         start;
    logic [7:0] reply;
    start = err_count;
    run_command(1'b0, SlotRgb, 8'h00, reply);
    if (reply !== last_rgb) report_mismatch("rgb read", last_rgb, reply);
    run_command(1'b0, SlotDebug, 8'h00, reply);
    if (reply !== last_dbg) report_mismatch("debug read", last_dbg, reply);
    run_command(1'b0, SlotCharlie, 8'h00, reply);
    if (reply !== last_chx) report_mismatch("charlieplex read", last_chx, reply);
    finish_test("read back", start);
  endtask

  initial begin
    seed      = 32'h0910_8128;
    err_count = 0;
    tests_run = 0;
    last_rgb  = '0;
    last_dbg  = '0;
    last_chx  = '0;
    rst_n     = 1'b0;
    uart_rx_n = 1'b1;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    check_reset_state();
    write_debug_bytes();
    write_rgb_levels();
    write_charlie_indices();
    // before read back so the rgb read also shows the level untouched
    probe_unmapped();
    read_back_slots();

    $display("tests run: %0d, errors: %0d", tests_run, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
source/bus_pkg.sv
source/uart_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/ctrl_uart.sv
source/bus_decoder.sv
source/peri_rgb_led.sv
source/peri_debug.sv
source/peri_charlieplex.sv
source/top.sv
verif/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
